// File: etx_pkg.sv
package etx_pkg;

   localparam int PW = 104;            // Mesh packet width
   localparam int AW = 32;             // Address width
   localparam int DW = 32;             // Data word width

   typedef logic [PW-1:0] packet_t;    // Whole mesh packet
   typedef logic [AW-1:0] addr_t;
   typedef logic [DW-1:0] data_t;
   typedef logic [3:0]    ctrlmode_t;
   typedef logic [7:0]    frame_t;     // Frame lane code

   // Packet field positions
   localparam int WRITE_BIT = 1;
   localparam int DMODE_LSB = 2;
   localparam int DMODE_MSB = 3;
   localparam int CTRL_LSB  = 4;
   localparam int CTRL_MSB  = 7;
   localparam int DST_LSB   = 8;
   localparam int DST_MSB   = 39;
   localparam int DATA_LSB  = 40;
   localparam int DATA_MSB  = 71;
   localparam int SRC_LSB   = 72;
   localparam int SRC_MSB   = 103;

   localparam int ADDR_HI_LSB = 20;    // Lowest dstaddr bit touched by remap

   // Frame lane codes
   localparam frame_t FRAME_HEAD = 8'h3f;   // Beat 0
   localparam frame_t FRAME_BODY = 8'hff;   // Beat 1
   localparam frame_t FRAME_IDLE = 8'h00;   // No beat on the link

endpackage

// File: etx_cfg_pkg.sv
package etx_cfg_pkg;

   localparam int REG_W   = 32;        // Register word width
   localparam int REMAP_W = 12;        // Remap mask and pattern width

   typedef logic [3:0]         cfg_addr_t;
   typedef logic [REG_W-1:0]   reg_t;
   typedef logic [REMAP_W-1:0] remap_t;

   // Register map
   localparam cfg_addr_t REG_TXCFG      = 4'd0;
   localparam cfg_addr_t REG_REMAP_MASK = 4'd1;
   localparam cfg_addr_t REG_REMAP_PAT  = 4'd2;

   // REG_TXCFG fields
   localparam int TXCFG_TX_EN    = 0;
   localparam int TXCFG_REMAP_EN = 1;
   localparam int TXCFG_BYPASS   = 2;
   localparam int TXCFG_CTRL_LSB = 4;
   localparam int TXCFG_CTRL_MSB = 7;

   // Reset values
   localparam reg_t   TXCFG_RESET = '0;   // Link disabled
   localparam remap_t REMAP_RESET = '0;

endpackage

// File: etx_intf.sv
`timescale 1ns/10ps

interface emesh_if import etx_pkg::*; ();

   logic    access;      // Packet valid
   packet_t packet;
   logic    rd_wait;     // Stall for read packets (write bit clear)
   logic    wr_wait;     // Stall for write packets

   modport src (
      output access,
      output packet,
      input  rd_wait,
      input  wr_wait
   );

   modport dst (
      input  access,
      input  packet,
      output rd_wait,
      output wr_wait
   );

endinterface

interface cfg_if import etx_pkg::*, etx_cfg_pkg::*; ();

   logic      tx_enable;
   logic      remap_enable;
   logic      ctrlmode_bypass;     // Keep the channel's own ctrlmode
   ctrlmode_t ctrlmode;            // Override value
   remap_t    remap_mask;
   remap_t    remap_pattern;

   modport master (
      output tx_enable,
      output remap_enable,
      output ctrlmode_bypass,
      output ctrlmode,
      output remap_mask,
      output remap_pattern
   );

   modport slave (
      input  tx_enable,
      input  remap_enable,
      input  ctrlmode_bypass,
      input  ctrlmode,
      input  remap_mask,
      input  remap_pattern
   );

endinterface

// File: etx_cfg.sv
`timescale 1ns/10ps

module etx_cfg import etx_cfg_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      cfg_write,
   input  cfg_addr_t cfg_addr,
   input  reg_t      cfg_wdata,
   output reg_t      cfg_rdata,
   cfg_if.master     cfg
);

   reg_t   txcfg_q;     // Whole word kept for read-back
   remap_t mask_q;
   remap_t pattern_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         txcfg_q   <= TXCFG_RESET;
         mask_q    <= REMAP_RESET;
         pattern_q <= REMAP_RESET;
      end else if (cfg_write) begin
         case (cfg_addr)
            REG_TXCFG:      txcfg_q   <= cfg_wdata;
            REG_REMAP_MASK: mask_q    <= cfg_wdata[REMAP_W-1:0];   // Upper bits dropped
            REG_REMAP_PAT:  pattern_q <= cfg_wdata[REMAP_W-1:0];
            default:        ;                                      // Unused address
         endcase
      end
   end

   // Combinational read-back
   always_comb begin
      case (cfg_addr)
         REG_TXCFG:      cfg_rdata = txcfg_q;
         REG_REMAP_MASK: cfg_rdata = {{(REG_W-REMAP_W){1'b0}}, mask_q};
         REG_REMAP_PAT:  cfg_rdata = {{(REG_W-REMAP_W){1'b0}}, pattern_q};
         default:        cfg_rdata = '0;
      endcase
   end

   // Fields out to the datapath
   assign cfg.tx_enable       = txcfg_q[TXCFG_TX_EN];
   assign cfg.remap_enable    = txcfg_q[TXCFG_REMAP_EN];
   assign cfg.ctrlmode_bypass = txcfg_q[TXCFG_BYPASS];
   assign cfg.ctrlmode        = txcfg_q[TXCFG_CTRL_MSB:TXCFG_CTRL_LSB];
   assign cfg.remap_mask      = mask_q;
   assign cfg.remap_pattern   = pattern_q;

endmodule

// File: etx_arbiter.sv
`timescale 1ns/10ps

module etx_arbiter import etx_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    txwr_access,
   input  packet_t txwr_packet,
   output logic    txwr_wait,
   input  logic    txrd_access,
   input  packet_t txrd_packet,
   output logic    txrd_wait,
   input  logic    txrr_access,
   input  packet_t txrr_packet,
   output logic    txrr_wait,
   cfg_if.slave    cfg,
   emesh_if.src    out,
   output logic    is_response
);

   typedef enum logic {
      ARB_EMPTY,
      ARB_HOLD
   } arb_state_t;

   arb_state_t state;
   packet_t    pkt_q;       // Output register
   packet_t    pkt_sel;     // Granted packet after override
   logic       out_stall;
   logic       can_load;
   logic       gnt_rr;
   logic       gnt_rd;
   logic       gnt_wr;
   logic       gnt_any;

   // Held packet blocked by the wait of its own type
   assign out_stall = (state == ARB_HOLD) &&
                      (pkt_q[WRITE_BIT] ? out.wr_wait : out.rd_wait);
   assign can_load  = !out_stall;   // Empty or draining this cycle

   // Fixed priority: responses, then reads, then writes
   assign gnt_rr  = can_load & txrr_access;
   assign gnt_rd  = can_load & txrd_access & ~txrr_access;
   assign gnt_wr  = can_load & txwr_access & ~txrr_access & ~txrd_access;
   assign gnt_any = gnt_rr | gnt_rd | gnt_wr;

   // Requesters that lose see wait
   assign txrr_wait = txrr_access & ~gnt_rr;
   assign txrd_wait = txrd_access & ~gnt_rd;
   assign txwr_wait = txwr_access & ~gnt_wr;

   always_comb begin
      if (txrr_access) begin
         pkt_sel = txrr_packet;
      end else if (txrd_access) begin
         pkt_sel = txrd_packet;
      end else begin
         pkt_sel = txwr_packet;
      end
      if (!cfg.ctrlmode_bypass) begin
         pkt_sel[CTRL_MSB:CTRL_LSB] = cfg.ctrlmode;   // Configured ctrlmode wins
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ARB_EMPTY;
         is_response <= 1'b0;
      end else if (can_load) begin
         state       <= gnt_any ? ARB_HOLD : ARB_EMPTY;
         is_response <= gnt_rr;                       // Remap skips responses
      end
   end

   // Payload only moves on a grant
   always_ff @(posedge clk) begin
      if (gnt_any) begin
         pkt_q <= pkt_sel;
      end
   end

   assign out.access = (state == ARB_HOLD);
   assign out.packet = pkt_q;

endmodule

// File: etx_remap.sv
`timescale 1ns/10ps

module etx_remap import etx_pkg::*, etx_cfg_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   cfg_if.slave cfg,
   input  logic is_response,    // Qualifies in.packet
   emesh_if.dst in,
   emesh_if.src out
);

   logic    valid;
   logic    out_stall;
   logic    load;
   packet_t pkt_q;
   packet_t pkt_new;
   addr_t   dst_in;
   remap_t  hi_new;

   assign out_stall = valid && (pkt_q[WRITE_BIT] ? out.wr_wait : out.rd_wait);
   assign load      = in.access & ~out_stall;

   // Full and stalled blocks both types
   assign in.rd_wait = out_stall;
   assign in.wr_wait = out_stall;

   // Mask selects pattern bits over the original upper address
   assign dst_in = in.packet[DST_MSB:DST_LSB];
   assign hi_new = (cfg.remap_pattern & cfg.remap_mask) |
                   (dst_in[AW-1:ADDR_HI_LSB] & ~cfg.remap_mask);

   always_comb begin
      pkt_new = in.packet;
      if (cfg.remap_enable && !is_response) begin
         pkt_new[DST_MSB:DST_LSB+ADDR_HI_LSB] = hi_new;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= load | out_stall;   // Refill or keep holding
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         pkt_q <= pkt_new;
      end
   end

   assign out.access = valid;
   assign out.packet = pkt_q;

endmodule

// File: etx_protocol.sv
`timescale 1ns/10ps

module etx_protocol import etx_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   cfg_if.slave        cfg,
   emesh_if.dst        in,
   input  logic        tx_rd_wait,
   input  logic        tx_wr_wait,
   output logic [63:0] tx_data_par,
   output frame_t      tx_frame_par
);

   typedef enum logic [1:0] {
      PRO_IDLE,
      PRO_HEAD,     // Beat 0 on the link
      PRO_BODY      // Beat 1 on the link
   } pro_state_t;

   pro_state_t  state;
   logic        busy;
   logic        take;
   logic [63:0] head_beat;
   logic [63:0] body_q;      // Beat 1 held for the next cycle
   addr_t       pkt_dst;
   addr_t       pkt_src;
   data_t       pkt_data;

   // Beat 1 slot is free for the next head
   assign busy = (state == PRO_HEAD);

   assign in.rd_wait = busy | ~cfg.tx_enable | tx_rd_wait;
   assign in.wr_wait = busy | ~cfg.tx_enable | tx_wr_wait;

   assign take = in.access & ~(in.packet[WRITE_BIT] ? in.wr_wait : in.rd_wait);

   assign pkt_dst  = in.packet[DST_MSB:DST_LSB];
   assign pkt_src  = in.packet[SRC_MSB:SRC_LSB];
   assign pkt_data = in.packet[DATA_MSB:DATA_LSB];

   // Header beat, unused bits zero
   assign head_beat = {pkt_dst,                           // 63..32
                       20'b0,
                       in.packet[CTRL_MSB:CTRL_LSB],      // 11..8
                       2'b0,
                       in.packet[DMODE_MSB:DMODE_LSB],    // 5..4
                       3'b0,
                       in.packet[WRITE_BIT]};             // 0

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= PRO_IDLE;
         tx_frame_par <= FRAME_IDLE;
         tx_data_par  <= '0;
      end else if (take) begin
         state        <= PRO_HEAD;
         tx_frame_par <= FRAME_HEAD;
         tx_data_par  <= head_beat;
      end else if (state == PRO_HEAD) begin
         state        <= PRO_BODY;
         tx_frame_par <= FRAME_BODY;
         tx_data_par  <= body_q;
      end else begin
         state        <= PRO_IDLE;    // Data lane returns to zero
         tx_frame_par <= FRAME_IDLE;
         tx_data_par  <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         body_q <= {pkt_src, pkt_data};
      end
   end

endmodule

// File: etx_core.sv
`timescale 1ns/10ps

module etx_core import etx_pkg::*, etx_cfg_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   // Write requests
   input  logic        txwr_access,
   input  packet_t     txwr_packet,
   output logic        txwr_wait,
   // Read requests
   input  logic        txrd_access,
   input  packet_t     txrd_packet,
   output logic        txrd_wait,
   // Read responses
   input  logic        txrr_access,
   input  packet_t     txrr_packet,
   output logic        txrr_wait,
   // Link side
   output logic [63:0] tx_data_par,
   output frame_t      tx_frame_par,
   input  logic        tx_rd_wait,
   input  logic        tx_wr_wait,
   // Register access
   input  logic        cfg_write,
   input  cfg_addr_t   cfg_addr,
   input  reg_t        cfg_wdata,
   output reg_t        cfg_rdata
);

   cfg_if   cfg_bus ();
   emesh_if arb_bus ();     // Arbiter to remap
   emesh_if rmp_bus ();     // Remap to protocol
   logic    is_response;

   etx_cfg u_cfg (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg_bus)
   );

   etx_arbiter u_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_access (txrd_access),
      .txrd_packet (txrd_packet),
      .txrd_wait   (txrd_wait),
      .txrr_access (txrr_access),
      .txrr_packet (txrr_packet),
      .txrr_wait   (txrr_wait),
      .cfg         (cfg_bus),
      .out         (arb_bus),
      .is_response (is_response)
   );

   etx_remap u_remap (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg         (cfg_bus),
      .is_response (is_response),
      .in          (arb_bus),
      .out         (rmp_bus)
   );

   etx_protocol u_protocol (
      .clk          (clk),
      .rst_n        (rst_n),
      .cfg          (cfg_bus),
      .in           (rmp_bus),
      .tx_rd_wait   (tx_rd_wait),
      .tx_wr_wait   (tx_wr_wait),
      .tx_data_par  (tx_data_par),
      .tx_frame_par (tx_frame_par)
   );

endmodule

// File: etx_core_sva.sv
`timescale 1ns/10ps

module etx_core_sva import etx_pkg::*; (
   input logic        clk,
   input logic        rst_n,
   input logic        txwr_access, txrd_access, txrr_access,
   input packet_t     txwr_packet, txrd_packet, txrr_packet,
   input logic        txwr_wait, txrd_wait, txrr_wait,
   input logic [63:0] tx_data_par,
   input frame_t      tx_frame_par
);

   // Stalled channel keeps its request
   a_rr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      txrr_access && txrr_wait |=> txrr_access && $stable(txrr_packet)) else $error("txrr hold");
   a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      txrd_access && txrd_wait |=> txrd_access && $stable(txrd_packet)) else $error("txrd hold");
   a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      txwr_access && txwr_wait |=> txwr_access && $stable(txwr_packet)) else $error("txwr hold");

   a_head_body: assert property (@(posedge clk) disable iff (!rst_n)
      tx_frame_par == FRAME_HEAD |=> tx_frame_par == FRAME_BODY) else $error("head not followed");

   a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
      tx_frame_par == FRAME_IDLE |-> tx_data_par == '0) else $error("data on idle lane");

endmodule

bind etx_core etx_core_sva u_sva (.*);

// File: tb_etx_core.sv
`timescale 1ns/10ps

module tb_etx_core import etx_pkg::*, etx_cfg_pkg::*; ();

   localparam int TMO = 2000;          // Cycles before a wait gives up

   logic clk, rst_n;
   logic txwr_access, txrd_access, txrr_access;
   packet_t txwr_packet, txrd_packet, txrr_packet;
   logic txwr_wait, txrd_wait, txrr_wait;
   logic [63:0] tx_data_par;
   frame_t tx_frame_par;
   logic tx_rd_wait, tx_wr_wait, cfg_write;
   cfg_addr_t cfg_addr;
   reg_t cfg_wdata, cfg_rdata;

   integer seed = 32'h85f2;
   int errors = 0;
   int checks = 0;
   int cycle = 0;
   logic [63:0] exp_head[$], exp_body[$];
   int exp_cyc[$], acc_ch[$];          // Acceptance cycle, channel id
   logic [63:0] body_exp;
   logic body_pending = 0;
   logic lat_flag = 0;                 // Next acceptance checks latency
   logic toggling = 0;
   reg_t sh_txcfg = '0;                // Model copy of the registers
   remap_t sh_mask = '0, sh_pat = '0;
   reg_t r;

   etx_core UUT (.*);

   initial begin
      clk = 0;
      forever #2 clk = ~clk;
   end

   task automatic timeout(string what);
      errors++;
      $display("Timeout while waiting for %s", what);
      $display("sim failed");
      $finish;
   endtask

   function automatic packet_t rand_pkt(logic wr);
      packet_t p;
      p = {$random(seed), $random(seed), $random(seed), $random(seed)};
      p[WRITE_BIT] = wr;               // Channel decides the type
      return p;
   endfunction

   // Beat 0 from the packing, override and remap rules
   function automatic logic [63:0] head_of(packet_t p, logic resp);
      addr_t d = p[DST_MSB:DST_LSB];
      ctrlmode_t c = sh_txcfg[2] ? p[CTRL_MSB:CTRL_LSB] : sh_txcfg[7:4];
      if (sh_txcfg[1] && !resp) begin
         d[31:20] = (d[31:20] & ~sh_mask) | (sh_pat & sh_mask);
      end
      return {d, 20'h0, c, 2'b0, p[DMODE_MSB:DMODE_LSB], 3'b0, p[WRITE_BIT]};
   endfunction

   task automatic accept(int ch, packet_t p);
      exp_head.push_back(head_of(p, ch == 0));
      exp_body.push_back({p[SRC_MSB:SRC_LSB], p[DATA_MSB:DATA_LSB]});
      exp_cyc.push_back(lat_flag ? cycle : -1);
      acc_ch.push_back(ch);
      lat_flag = 0;
   endtask

   // Model and checker, sampled mid-cycle
   always @(negedge clk) begin
      int c;
      if (rst_n) begin
         cycle++;
         if (txrr_access && !txrr_wait) accept(0, txrr_packet);   // Transfers next edge
         if (txrd_access && !txrd_wait) accept(1, txrd_packet);
         if (txwr_access && !txwr_wait) accept(2, txwr_packet);
         checks++;
         if (tx_frame_par == FRAME_HEAD) begin
            if (exp_head.size() == 0) begin
               $display("Frame head on the link with no packet expected");
               errors++;
            end else begin
               c = exp_cyc.pop_front();
               if (tx_data_par !== exp_head[0]) begin
                  $display("ERROR tx_data_par head exp %h got %h", exp_head[0], tx_data_par);
                  errors++;
               end
               if (c >= 0 && cycle - c != 3) begin   // Edge N+2 after acceptance
                  $display("ERROR head latency exp %h got %h", 3, cycle - c);
                  errors++;
               end
               void'(exp_head.pop_front());
               body_exp = exp_body.pop_front();
               body_pending = 1;
            end
         end else if (tx_frame_par == FRAME_BODY) begin
            if (!body_pending) begin
               $display("Frame body on the link without a head before it");
               errors++;
            end else if (tx_data_par !== body_exp) begin
               $display("ERROR tx_data_par body exp %h got %h", body_exp, tx_data_par);
               errors++;
            end
            body_pending = 0;
         end else begin
            if (tx_frame_par !== FRAME_IDLE) begin
               $display("ERROR tx_frame_par idle exp %h got %h", FRAME_IDLE, tx_frame_par);
               errors++;
            end
            if (tx_data_par !== '0) begin
               $display("ERROR tx_data_par idle exp %h got %h", 64'h0, tx_data_par);
               errors++;
            end
         end
      end
   end

   task automatic set_ch(int ch, logic a, packet_t p);
      case (ch)
         0: begin
            txrr_access = a;
            txrr_packet = p;
         end
         1: begin
            txrd_access = a;
            txrd_packet = p;
         end
         default: begin
            txwr_access = a;
            txwr_packet = p;
         end
      endcase
   endtask

   // One transfer on a channel, held while its wait is high
   task automatic send(int ch, packet_t p);
      int t = 0;
      logic w = 1;
      @(posedge clk);
      #1;
      set_ch(ch, 1, p);
      while (w && t < TMO) begin
         @(negedge clk);
         w = (ch == 0) ? txrr_wait : (ch == 1) ? txrd_wait : txwr_wait;
         t++;
      end
      if (w) timeout("a channel wait to drop");
      @(posedge clk);
      #1;
      set_ch(ch, 0, p);
   endtask

   task automatic burst(int ch, int n);
      repeat (n) begin
         repeat ($random(seed) & 3) @(posedge clk);
         send(ch, rand_pkt(ch == 2));
      end
   endtask

   task automatic write_reg(cfg_addr_t a, reg_t d);
      @(posedge clk);
      #1;
      cfg_write = 1;
      cfg_addr = a;
      cfg_wdata = d;
      @(posedge clk);
      #1;
      cfg_write = 0;
      case (a)                         // Model follows the register write
         REG_TXCFG: sh_txcfg = d;
         REG_REMAP_MASK: sh_mask = d[11:0];
         REG_REMAP_PAT: sh_pat = d[11:0];
         default: ;
      endcase
   endtask

   task automatic read_check(cfg_addr_t a, reg_t e);
      @(posedge clk);
      #1;
      cfg_addr = a;
      #1;
      checks++;
      if (cfg_rdata !== e) begin
         $display("ERROR cfg_rdata addr %h exp %h got %h", a, e, cfg_rdata);
         errors++;
      end
   endtask

   task automatic drain();
      int t = 0;
      while ((exp_head.size() != 0 || body_pending) && t < TMO) begin
         @(negedge clk);
         t++;
      end
      if (t >= TMO) timeout("the link to drain");
   endtask

   initial begin
      int t = 0;
      rst_n = 0;
      cfg_write = 0;
      cfg_addr = '0;
      cfg_wdata = '0;
      tx_rd_wait = 0;
      tx_wr_wait = 0;
      set_ch(0, 0, '0);
      set_ch(1, 0, '0);
      set_ch(2, 0, '0);
      repeat (2) @(posedge clk);
      #1 rst_n = 1;
      // Register read-back
      r = $random(seed);
      write_reg(REG_TXCFG, r);
      write_reg(REG_REMAP_MASK, ~r);
      write_reg(REG_REMAP_PAT, r ^ 32'h5a5);
      read_check(REG_TXCFG, r);
      read_check(REG_REMAP_MASK, {20'h0, sh_mask});
      read_check(REG_REMAP_PAT, {20'h0, sh_pat});
      read_check(4'd5, '0);
      // Link disabled, pipeline fills and stalls
      write_reg(REG_TXCFG, 32'h50);
      fork
         send(0, rand_pkt(0));
         send(1, rand_pkt(0));
         send(2, rand_pkt(1));
         begin
            while (!(txwr_wait && !txrr_access && !txrd_access) && t < TMO) begin
               @(negedge clk);
               t++;
            end
            if (t >= TMO) timeout("the stalled pipeline");
            repeat (6) begin
               @(negedge clk);
               checks++;
               if (!txwr_wait || tx_frame_par !== FRAME_IDLE) begin
                  $display("Channel accepted or frame sent while the link is disabled");
                  errors++;
               end
            end
            write_reg(REG_TXCFG, 32'h51);
         end
      join
      drain();
      // Priority with override, latency on the first
      write_reg(REG_TXCFG, 32'h71);
      acc_ch.delete();
      lat_flag = 1;
      fork
         send(0, rand_pkt(0));
         send(1, rand_pkt(0));
         send(2, rand_pkt(1));
      join
      drain();
      checks++;
      if (acc_ch.size() != 3 || acc_ch[0] != 0 || acc_ch[1] != 1 || acc_ch[2] != 2) begin
         $display("Channels were not granted in the order txrr, txrd, txwr");
         errors++;
      end
      // Ctrlmode pass-through
      write_reg(REG_TXCFG, 32'h75);
      fork
         burst(0, 4);
         burst(1, 4);
         burst(2, 4);
      join
      drain();
      // Remap with random mask and pattern
      write_reg(REG_REMAP_MASK, $random(seed));
      write_reg(REG_REMAP_PAT, $random(seed));
      write_reg(REG_TXCFG, 32'h33);
      fork
         burst(0, 6);
         burst(1, 6);
         burst(2, 6);
      join
      drain();
      // Read passes while writes are stalled at the link
      @(posedge clk);
      #1;
      tx_wr_wait = 1;
      send(1, rand_pkt(0));
      drain();
      @(posedge clk);
      #1;
      tx_wr_wait = 0;
      // Random link back-pressure until every channel has sent its share
      toggling = 1;
      fork
         begin
            fork
               burst(0, 40);
               burst(1, 40);
               burst(2, 40);
            join
            toggling = 0;
         end
         while (toggling) begin
            @(posedge clk);
            #1;
            tx_rd_wait = ($random(seed) & 3) == 0;
            tx_wr_wait = ($random(seed) & 3) == 0;
         end
      join
      tx_rd_wait = 0;
      tx_wr_wait = 0;
      drain();
      $display("checks %0d errors %0d queued %0d", checks, errors, exp_head.size());
      if (errors == 0 && exp_head.size() == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: build.f
etx_pkg.sv
etx_cfg_pkg.sv
etx_intf.sv
etx_cfg.sv
etx_arbiter.sv
etx_remap.sv
etx_protocol.sv
etx_core.sv
etx_core_sva.sv
tb_etx_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_etx_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
